// File: logic/nfcCommandPkg.sv
package nfcCommandPkg;

    // Flash array geometry and the target this front end answers to.
    localparam int numberOfWays = 4;
    localparam logic [4:0] targetIdValue = 5'b00101;

    // Bit of the generator Ready and LastStep vectors for the CA latch atom.
    localparam int atomCaBit = 3;

    // Command bytes sent on the flash bus.
    localparam logic [7:0] flashResetCode = 8'hFF;
    localparam logic [7:0] eraseSetupCode = 8'h60;
    localparam logic [7:0] eraseConfirmCode = 8'hD0;

    typedef enum logic [5:0] {
        opReset      = 6'h01,
        opEraseBlock = 6'h06,
        opSelectWay  = 6'h20,
        opSetRow     = 6'h24
    } opcodeT;

    // One-hot atom codes, the set bit matches the Ready and LastStep index.
    typedef enum logic [7:0] {
        atomIdle    = 8'h00,
        atomCaLatch = 8'h08
    } atomCommandT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  targetId;
        logic [31:0] address;
    } hostCommandT;

    typedef struct packed {
        atomCommandT               command;
        // Number of CA bytes.
        logic [2:0]                commandOption;
        logic [numberOfWays - 1:0] targetWay;
        logic [15:0]               numOfData;
        logic                      caSelect;
        // First byte on the bus sits in the top byte.
        logic [39:0]               caData;
    } atomRequestT;

endpackage

// File: logic/nfcTargetRegister.sv
module nfcTargetRegister
    import nfcCommandPkg::*;
(
    input  logic                      iSystemClock,
    input  logic                      iReset,
    input  hostCommandT               command,
    input  logic                      commandValid,
    input  logic                      allIdle,
    output logic [numberOfWays - 1:0] wayMask,
    output logic [23:0]               rowAddress
);

    logic accept;
    logic selectWay;
    logic setRow;

    assign accept = commandValid && allIdle && (command.targetId == targetIdValue);
    assign selectWay = accept && (command.opcode == opSelectWay);
    assign setRow = accept && (command.opcode == opSetRow);

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            wayMask <= numberOfWays'(1);
            rowAddress <= '0;
        end else begin
            if (selectWay) begin
                // Way number in the low address bits becomes a one-hot mask.
                wayMask <= numberOfWays'(1) << command.address[1:0];
            end
            if (setRow) begin
                rowAddress <= command.address[23:0];
            end
        end
    end

    wayMaskOneHot: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        $onehot(wayMask)
    ) else $error("wayMask is not one-hot: %h", wayMask);

endmodule

// File: logic/nfcResetCommand.sv
module nfcResetCommand
    import nfcCommandPkg::*;
(
    input  logic                      iSystemClock,
    input  logic                      iReset,
    input  hostCommandT               command,
    input  logic                      commandValid,
    input  logic                      allIdle,
    input  logic [numberOfWays - 1:0] wayMask,
    input  logic [7:0]                atomReady,
    input  logic [7:0]                atomLastStep,
    output atomRequestT               request,
    output logic                      idle
);

    typedef enum logic [1:0] {
        stateIdle,
        stateIssue,
        stateWaitLast
    } stateT;

    stateT state;
    logic accept;
    logic [numberOfWays - 1:0] selectedWay;

    assign accept = commandValid && allIdle && (command.targetId == targetIdValue)
                    && (command.opcode == opReset);

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            state <= stateIdle;
        end else begin
            case (state)
                stateIdle: begin
                    if (accept) begin
                        state <= stateIssue;
                    end
                end
                stateIssue: begin
                    if (atomReady[atomCaBit]) begin
                        state <= stateWaitLast;
                    end
                end
                stateWaitLast: begin
                    if (atomLastStep[atomCaBit]) begin
                        state <= stateIdle;
                    end
                end
                default: state <= stateIdle;
            endcase
        end
    end

    // Way is fixed for the whole command.
    always_ff @(posedge iSystemClock) begin
        if (accept) begin
            selectedWay <= wayMask;
        end
    end

    always_comb begin
        request = '0;
        if (state == stateIssue) begin
            request.command = atomCaLatch;
            request.commandOption = 3'd1;
            request.targetWay = selectedWay;
            request.caSelect = 1'b0;
            request.caData = {flashResetCode, 32'h0};
        end
    end

    assign idle = (state == stateIdle);

    // Generator back-pressure must not disturb the pending request.
    requestHeld: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        (state == stateIssue && !atomReady[atomCaBit])
            |=> (state == stateIssue && $stable(request))
    ) else $error("reset request changed while waiting for Ready");

endmodule

// File: logic/nfcEraseCommand.sv
module nfcEraseCommand
    import nfcCommandPkg::*;
(
    input  logic                      iSystemClock,
    input  logic                      iReset,
    input  hostCommandT               command,
    input  logic                      commandValid,
    input  logic                      allIdle,
    input  logic [numberOfWays - 1:0] wayMask,
    input  logic [23:0]               rowAddress,
    input  logic [7:0]                atomReady,
    input  logic [7:0]                atomLastStep,
    input  logic [numberOfWays - 1:0] readyBusy,
    output atomRequestT               request,
    output logic                      idle
);

    typedef enum logic [1:0] {
        stateIdle,
        stateIssue,
        stateWaitLast,
        stateWaitReady
    } stateT;

    stateT state;
    logic accept;
    logic wayReady;
    logic [numberOfWays - 1:0] selectedWay;
    logic [23:0] selectedRow;

    assign accept = commandValid && allIdle && (command.targetId == targetIdValue)
                    && (command.opcode == opEraseBlock);

    // Ready/busy is high when the way has finished the erase.
    assign wayReady = |(readyBusy & selectedWay);

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            state <= stateIdle;
        end else begin
            case (state)
                stateIdle: begin
                    if (accept) begin
                        state <= stateIssue;
                    end
                end
                stateIssue: begin
                    if (atomReady[atomCaBit]) begin
                        state <= stateWaitLast;
                    end
                end
                stateWaitLast: begin
                    if (atomLastStep[atomCaBit]) begin
                        state <= stateWaitReady;
                    end
                end
                stateWaitReady: begin
                    if (wayReady) begin
                        state <= stateIdle;
                    end
                end
                default: state <= stateIdle;
            endcase
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (accept) begin
            selectedWay <= wayMask;
            selectedRow <= rowAddress;
        end
    end

    // Setup byte, three row bytes high first, then confirm.
    always_comb begin
        request = '0;
        if (state == stateIssue) begin
            request.command = atomCaLatch;
            request.commandOption = 3'd5;
            request.targetWay = selectedWay;
            request.caSelect = 1'b1;
            request.caData = {eraseSetupCode, selectedRow, eraseConfirmCode};
        end
    end

    assign idle = (state == stateIdle);

    waitForWay: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        (state == stateWaitReady && !wayReady) |=> (state == stateWaitReady)
    ) else $error("erase left waitReady while way %h was busy", selectedWay);

endmodule

// File: logic/nfcAtomCommandMux.sv
module nfcAtomCommandMux
    import nfcCommandPkg::*;
(
    input  atomRequestT resetRequest,
    input  atomRequestT eraseRequest,
    input  logic        resetBusy,
    input  logic        eraseBusy,
    output atomRequestT request
);

    // Only one executor can own the generator, the host is held off otherwise.
    always_comb begin
        request = '0;
        if (resetBusy) begin
            request = resetRequest;
        end else if (eraseBusy) begin
            request = eraseRequest;
        end
    end

    always_comb begin
        singleOwner: assert (!(resetBusy && eraseBusy))
            else $error("reset and erase executors busy together");
    end

endmodule

// File: logic/nfcCommandIssueTop.sv
module nfcCommandIssueTop
    import nfcCommandPkg::*;
(
    input  logic                      iSystemClock,
    input  logic                      iReset,
    input  hostCommandT               command,
    input  logic                      commandValid,
    output logic                      commandReady,
    input  logic [7:0]                atomReady,
    input  logic [7:0]                atomLastStep,
    input  logic [numberOfWays - 1:0] readyBusy,
    output atomRequestT               atomRequest,
    output logic [numberOfWays - 1:0] wayReadyBusy
);

    logic [numberOfWays - 1:0] wayMask;
    logic [23:0] rowAddress;
    atomRequestT resetRequest;
    atomRequestT eraseRequest;
    logic resetIdle;
    logic eraseIdle;

    // Host may issue only when every executor is idle.
    assign commandReady = resetIdle & eraseIdle;
    assign wayReadyBusy = readyBusy;

    nfcTargetRegister targetRegister (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .command      (command),
        .commandValid (commandValid),
        .allIdle      (commandReady),
        .wayMask      (wayMask),
        .rowAddress   (rowAddress)
    );

    nfcResetCommand resetCommand (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .command      (command),
        .commandValid (commandValid),
        .allIdle      (commandReady),
        .wayMask      (wayMask),
        .atomReady    (atomReady),
        .atomLastStep (atomLastStep),
        .request      (resetRequest),
        .idle         (resetIdle)
    );

    nfcEraseCommand eraseCommand (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .command      (command),
        .commandValid (commandValid),
        .allIdle      (commandReady),
        .wayMask      (wayMask),
        .rowAddress   (rowAddress),
        .atomReady    (atomReady),
        .atomLastStep (atomLastStep),
        .readyBusy    (readyBusy),
        .request      (eraseRequest),
        .idle         (eraseIdle)
    );

    nfcAtomCommandMux atomCommandMux (
        .resetRequest (resetRequest),
        .eraseRequest (eraseRequest),
        .resetBusy    (!resetIdle),
        .eraseBusy    (!eraseIdle),
        .request      (atomRequest)
    );

endmodule

// File: tests/nfcCommandIssueTb.sv
module nfcCommandIssueTb
    import nfcCommandPkg::*;
();

    localparam int tableSize = 9;
    localparam int timeoutCycles = 200;
    localparam int quietCycles = 20;
    localparam logic [7:0] caBitMask = 8'(1) << atomCaBit;
    localparam atomRequestT idleRequest = '0;

    typedef struct packed {
        hostCommandT command;
        logic        hasRequest;
        atomRequestT expected;
    } stimulusT;

    logic                      iSystemClock;
    logic                      iReset;
    hostCommandT               command;
    logic                      commandValid;
    logic                      commandReady;
    logic [7:0]                atomReady;
    logic [7:0]                atomLastStep;
    logic [numberOfWays - 1:0] readyBusy;
    atomRequestT               atomRequest;
    logic [numberOfWays - 1:0] wayReadyBusy;

    stimulusT stimulus [tableSize];
    int errorCount;
    int failedTests;

    nfcCommandIssueTop u_dut (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .command      (command),
        .commandValid (commandValid),
        .commandReady (commandReady),
        .atomReady    (atomReady),
        .atomLastStep (atomLastStep),
        .readyBusy    (readyBusy),
        .atomRequest  (atomRequest),
        .wayReadyBusy (wayReadyBusy)
    );

    initial begin
        iSystemClock = 1'b0;
        forever #20 iSystemClock = ~iSystemClock;
    end

    task automatic checkRequest(input string name, input atomRequestT actual,
                                input atomRequestT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errorCount++;
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic checkWays(input string name, input logic [numberOfWays - 1:0] actual,
                             input logic [numberOfWays - 1:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    function automatic hostCommandT makeCommand(input opcodeT opcode, input logic [4:0] targetId,
                                                input logic [31:0] address);
        hostCommandT result;
        result.opcode = opcode;
        result.targetId = targetId;
        result.address = address;
        return result;
    endfunction

    // Expected CA latch request as the generator should see it.
    function automatic atomRequestT makeRequest(input logic [numberOfWays - 1:0] way,
                                                input logic [2:0] option, input logic caSelect,
                                                input logic [39:0] caData);
        atomRequestT result;
        result = '0;
        result.command = atomCaLatch;
        result.commandOption = option;
        result.targetWay = way;
        result.caSelect = caSelect;
        result.caData = caData;
        return result;
    endfunction

    // One sampled cycle, then on to the next rising edge.
    task automatic checkCycle(input atomRequestT expected, input logic expectedReady);
        @(negedge iSystemClock);
        checkRequest("atomRequest", atomRequest, expected);
        checkBit("commandReady", commandReady, expectedReady);
        checkWays("wayReadyBusy", wayReadyBusy, readyBusy);
        @(posedge iSystemClock);
    endtask

    task automatic sendCommand(input hostCommandT value);
        @(posedge iSystemClock);
        command <= value;
        commandValid <= 1'b1;
        @(posedge iSystemClock);
        commandValid <= 1'b0;
    endtask

    task automatic waitForReady();
        int count;
        logic seen;
        seen = 1'b0;
        for (count = 0; count < timeoutCycles && !seen; count++) begin
            @(negedge iSystemClock);
            checkWays("wayReadyBusy", wayReadyBusy, readyBusy);
            seen = commandReady;
        end
        if (!seen) begin
            errorCount++;
            $display("commandReady did not return within %0d cycles", timeoutCycles);
        end
        @(posedge iSystemClock);
    endtask

    // Generator model for one accepted command.
    task automatic runRequest(input stimulusT entry);
        int readyDelay;
        int lastDelay;
        int busyDelay;
        logic isErase;
        hostCommandT stray;
        logic [numberOfWays - 1:0] busyWay;
        isErase = (entry.command.opcode == opEraseBlock);
        stray = entry.command;
        stray.opcode = isErase ? opReset : opEraseBlock;
        readyDelay = $urandom % 6;
        lastDelay = $urandom % 6;
        busyDelay = $urandom % 9;
        busyWay = entry.expected.targetWay;
        sendCommand(entry.command);
        @(negedge iSystemClock);
        checkRequest("atomRequest", atomRequest, entry.expected);
        checkBit("commandReady", commandReady, 1'b0);
        @(posedge iSystemClock);
        // Second executor must stay off while the first one runs.
        command <= stray;
        commandValid <= 1'b1;
        if (isErase) begin
            readyBusy <= ~busyWay;
        end
        checkCycle(entry.expected, 1'b0);
        commandValid <= 1'b0;
        repeat (readyDelay) checkCycle(entry.expected, 1'b0);
        atomReady <= caBitMask;
        checkCycle(entry.expected, 1'b0);
        atomReady <= '0;
        repeat (lastDelay) checkCycle(idleRequest, 1'b0);
        atomLastStep <= caBitMask;
        checkCycle(idleRequest, 1'b0);
        atomLastStep <= '0;
        if (isErase) begin
            repeat (busyDelay) checkCycle(idleRequest, 1'b0);
            readyBusy <= '1;
        end else begin
            @(negedge iSystemClock);
            checkBit("commandReady", commandReady, 1'b1);
        end
        waitForReady();
    endtask

    initial begin
        int index;
        int errorsBefore;
        iReset = 1'b1;
        command = '0;
        commandValid = 1'b0;
        atomReady = '0;
        atomLastStep = '0;
        readyBusy = '1;
        errorCount = 0;
        failedTests = 0;
        void'($urandom(22102));

        stimulus[0] = {makeCommand(opSelectWay, targetIdValue, 32'd2), 1'b0, idleRequest};
        stimulus[1] = {makeCommand(opReset, targetIdValue, 32'd0), 1'b1,
                       makeRequest(4'b0100, 3'd1, 1'b0, 40'hFF_0000_0000)};
        stimulus[2] = {makeCommand(opSetRow, targetIdValue, 32'h0012_3456), 1'b0, idleRequest};
        stimulus[3] = {makeCommand(opSelectWay, targetIdValue, 32'd1), 1'b0, idleRequest};
        stimulus[4] = {makeCommand(opEraseBlock, targetIdValue, 32'd0), 1'b1,
                       makeRequest(4'b0010, 3'd5, 1'b1, 40'h60_1234_56D0)};
        stimulus[5] = {makeCommand(opReset, 5'b00110, 32'd0), 1'b0, idleRequest};
        stimulus[6] = {makeCommand(opSelectWay, 5'b10101, 32'd3), 1'b0, idleRequest};
        stimulus[7] = {makeCommand(opcodeT'(6'h3F), targetIdValue, 32'd0), 1'b0, idleRequest};
        // Way must still be 1 after the rejected select.
        stimulus[8] = stimulus[4];

        repeat (4) @(posedge iSystemClock);
        iReset <= 1'b0;

        checkCycle(idleRequest, 1'b1);
        if (errorCount != 0) begin
            failedTests++;
        end
        $display("test reset state: %s", (errorCount == 0) ? "passed" : "failed");

        for (index = 0; index < tableSize; index++) begin
            errorsBefore = errorCount;
            if (stimulus[index].hasRequest) begin
                runRequest(stimulus[index]);
            end else begin
                sendCommand(stimulus[index].command);
                repeat (quietCycles) checkCycle(idleRequest, 1'b1);
            end
            if (errorCount != errorsBefore) begin
                failedTests++;
            end
            $display("test %0d opcode %h target %h: %s", index, stimulus[index].command.opcode,
                     stimulus[index].command.targetId,
                     (errorCount == errorsBefore) ? "passed" : "failed");
        end

        $display("tests run %0d, tests failed %0d, check errors %0d", tableSize + 1,
                 failedTests, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
logic/nfcCommandPkg.sv
logic/nfcTargetRegister.sv
logic/nfcResetCommand.sv
logic/nfcEraseCommand.sv
logic/nfcAtomCommandMux.sv
logic/nfcCommandIssueTop.sv
tests/nfcCommandIssueTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module nfcCommandIssueTb -f all.f

simOutput=$(./obj_dir/VnfcCommandIssueTb) || true
printf '%s\n' "$simOutput"

if printf '%s\n' "$simOutput" | grep -qx 'STATUS: PASS'; then
    exit 0
fi
exit 1
